// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_mips_cpu_bus
FILELIST := mips_cpu.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

import mips_pkg::*;

// Sparse word memory keyed by byte address
typedef bit [31:0] mem_image_t [bit [31:0]];

function automatic bit [31:0] enc_r(funct_t fn, bit [4:0] rs, bit [4:0] rt, bit [4:0] rd,
                                    bit [4:0] sh = 5'd0);
    return {6'd0, rs, rt, rd, sh, fn};
endfunction

function automatic bit [31:0] enc_i(opcode_t op, bit [4:0] rs, bit [4:0] rt, bit [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Destination is a byte address inside the current 256 MB region
function automatic bit [31:0] enc_j(bit [31:0] dest);
    return {OP_J, dest[27:2]};
endfunction

// Appends one instruction at the running program address
function automatic void prog_add(ref mem_image_t mem, ref bit [31:0] at, input bit [31:0] ins);
    mem[at] = ins;
    at += 32'd4;
endfunction

// Runs the image from RESET_VECTOR and returns $v0
// Stores land in mem and unknown codes stop the run
function automatic bit [31:0] ref_run(ref mem_image_t mem, input int max_steps);
    bit [31:0] r [NUM_REGS];
    bit [31:0] pc;
    bit [31:0] nx;
    bit [31:0] ins;
    bit [31:0] a;
    bit [31:0] b;
    bit [31:0] se;
    bit [4:0]  rt;
    bit [4:0]  rd;
    bit [4:0]  sh;
    pc = RESET_VECTOR;
    for (int step = 0; step < max_steps && pc != HALT_ADDRESS; step++) begin
        ins = mem.exists(pc) ? mem[pc] : 32'h0;
        a   = r[ins[25:21]];
        b   = r[ins[20:16]];
        rt  = ins[20:16];
        rd  = ins[15:11];
        sh  = ins[10:6];
        se  = {{16{ins[15]}}, ins[15:0]};
        nx  = pc + 32'd4;
        case (opcode_t'(ins[31:26]))
            OP_R: begin
                case (funct_t'(ins[5:0]))
                    FN_ADDU: r[rd] = a + b;
                    FN_SUBU: r[rd] = a - b;
                    FN_AND:  r[rd] = a & b;
                    FN_OR:   r[rd] = a | b;
                    FN_XOR:  r[rd] = a ^ b;
                    FN_SLT:  r[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: r[rd] = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  r[rd] = b << sh;
                    FN_SRL:  r[rd] = b >> sh;
                    FN_SRA:  r[rd] = $signed(b) >>> sh;
                    FN_SLLV: r[rd] = b << a[4:0];
                    FN_SRLV: r[rd] = b >> a[4:0];
                    FN_SRAV: r[rd] = $signed(b) >>> a[4:0];
                    FN_JR:   nx = a;
                    default: return r[REG_V0];
                endcase
            end
            OP_J:     nx = {pc[31:28], ins[25:0], 2'b00};
            OP_BEQ:   nx = (a == b) ? nx + {se[29:0], 2'b00} : nx;
            OP_BNE:   nx = (a != b) ? nx + {se[29:0], 2'b00} : nx;
            OP_ADDIU: r[rt] = a + se;
            OP_SLTI:  r[rt] = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            OP_SLTIU: r[rt] = (a < se) ? 32'd1 : 32'd0;
            OP_ANDI:  r[rt] = a & {16'h0, ins[15:0]};
            OP_ORI:   r[rt] = a | {16'h0, ins[15:0]};
            OP_XORI:  r[rt] = a ^ {16'h0, ins[15:0]};
            OP_LUI:   r[rt] = {ins[15:0], 16'h0};
            OP_LW:    r[rt] = mem.exists(a + se) ? mem[a + se] : 32'h0;
            OP_SW:    mem[a + se] = b;
            default:  return r[REG_V0];
        endcase
        r[0] = 32'h0;
        pc   = nx;
    end
    return r[REG_V0];
endfunction

`endif

// File: bench/tb_mips_cpu_bus.sv
module tb_mips_cpu_bus import mips_pkg::*; ();

`include "mips_ref_model.svh"

    localparam int        DRIVE_DELAY  = 2;
    localparam int        RESET_CYCLES = 5;
    localparam int        HOLD_CYCLES  = 8;
    localparam int        MAX_WAIT     = 3;
    localparam int        NUM_TESTS    = 5;
    localparam int        NUM_RUNS     = NUM_TESTS + 4;
    localparam bit [31:0] DATA_BASE    = 32'h0000_1000;
    localparam bit [4:0]  R0 = 5'd0;
    localparam bit [4:0]  V0 = 5'd2;
    localparam bit [4:0]  RX = 5'd8;
    localparam bit [4:0]  RY = 5'd9;
    localparam bit [4:0]  RT = 5'd10;
    localparam bit [4:0]  RB = 5'd20;
    localparam bit [4:0]  RC = 5'd21;

    logic       clk;
    logic       reset;
    logic       waitrequest;
    word_t      readdata;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       read;
    logic       write;
    word_t      writedata;
    logic [3:0] byteenable;

    mem_image_t imgs [NUM_TESTS];
    mem_image_t build_img;
    mem_image_t dut_mem;
    mem_image_t exp_mem;
    bit [31:0]  pc_at;
    bit [31:0]  data_off;
    bit [31:0]  rng;
    bit [31:0]  exp_v0;
    bit         wait_enable;
    int         wait_run;
    int         cycles;
    int         cycle_limit;
    int         errors;
    int         run_errors;
    int         failed_runs;
    event       compare_req;
    event       compare_ack;
    string      test_names [NUM_TESTS];

    mips_cpu_bus i_mips_cpu_bus (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic bit [31:0] xorshift32(bit [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic bit [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic bit [31:0] dut_word(bit [31:0] a);
        return dut_mem.exists(a) ? dut_mem[a] : 32'h0;
    endfunction

    function automatic bit [31:0] exp_word(bit [31:0] a);
        return exp_mem.exists(a) ? exp_mem[a] : 32'h0;
    endfunction

    task automatic note_error();
        errors++;
        run_errors++;
    endtask

    task automatic put(bit [31:0] ins);
        prog_add(build_img, pc_at, ins);
    endtask

    task automatic load_const(bit [4:0] rd, bit [31:0] value);
        put(enc_i(OP_LUI, R0, rd, value[31:16]));
        put(enc_i(OP_ORI, rd, rd, value[15:0]));
    endtask

    // Result is stored and summed into $v0
    task automatic keep_result(bit [31:0] ins);
        put(ins);
        put(enc_i(OP_SW, RB, RT, data_off[15:0]));
        put(enc_r(FN_ADDU, V0, RT, V0));
        data_off += 32'd4;
    endtask

    task automatic add_v0(bit [15:0] k);
        put(enc_i(OP_ADDIU, V0, V0, k));
    endtask

    task automatic start_program();
        build_img.delete();
        pc_at    = RESET_VECTOR;
        data_off = 32'h0;
        load_const(RB, DATA_BASE);
    endtask

    task automatic finish_program(int t);
        put(enc_r(FN_JR, R0, R0, R0));
        imgs[t] = build_img;
    endtask

    task automatic build_alu_test();
        bit [31:0] x;
        bit [31:0] y;
        // x negative and y positive so SLT and SLTU disagree
        x = next_rand() | 32'h8000_0000;
        y = next_rand() & 32'h7FFF_FFFF;
        start_program();
        load_const(RX, x);
        load_const(RY, y);
        keep_result(enc_r(FN_ADDU, RX, RY, RT));
        keep_result(enc_r(FN_SUBU, RX, RY, RT));
        keep_result(enc_r(FN_AND, RX, RY, RT));
        keep_result(enc_r(FN_OR, RX, RY, RT));
        keep_result(enc_r(FN_XOR, RX, RY, RT));
        keep_result(enc_r(FN_SLT, RX, RY, RT));
        keep_result(enc_r(FN_SLTU, RX, RY, RT));
        keep_result(enc_r(FN_SLL, R0, RY, RT, 5'd7));
        keep_result(enc_r(FN_SRL, R0, RX, RT, 5'd13));
        keep_result(enc_r(FN_SRA, R0, RX, RT, 5'd19));
        keep_result(enc_r(FN_SLLV, RY, RX, RT));
        keep_result(enc_r(FN_SRLV, RY, RX, RT));
        keep_result(enc_r(FN_SRAV, RY, RX, RT));
        finish_program(0);
    endtask

    task automatic build_imm_test();
        start_program();
        load_const(RX, next_rand());
        keep_result(enc_i(OP_ADDIU, RX, RT, 16'hFFFD));
        keep_result(enc_i(OP_ADDIU, R0, RT, 16'h8000));
        keep_result(enc_i(OP_SLTI, R0, RT, 16'hFFFF));
        keep_result(enc_i(OP_SLTI, RX, RT, 16'h8000));
        keep_result(enc_i(OP_SLTIU, R0, RT, 16'hFFFF));
        keep_result(enc_i(OP_SLTIU, RX, RT, 16'h8000));
        keep_result(enc_i(OP_ANDI, RX, RT, 16'hF0F0));
        keep_result(enc_i(OP_ORI, R0, RT, 16'h8001));
        keep_result(enc_i(OP_XORI, RX, RT, 16'hFFFF));
        keep_result(enc_i(OP_LUI, R0, RT, 16'h8765));
        finish_program(1);
    endtask

    task automatic build_mem_test();
        start_program();
        load_const(RX, next_rand());
        load_const(RY, next_rand());
        load_const(RC, DATA_BASE + 32'h100);
        put(enc_i(OP_SW, RB, RX, 16'h0010));
        put(enc_i(OP_LW, RB, V0, 16'h0010));
        // Negative offset from the second base
        put(enc_i(OP_SW, RC, RY, 16'hFFF8));
        put(enc_i(OP_LW, RC, RT, 16'hFFF8));
        put(enc_r(FN_ADDU, V0, RT, V0));
        build_img[DATA_BASE + 32'h40] = next_rand();
        put(enc_i(OP_LW, RB, RT, 16'h0040));
        put(enc_i(OP_SW, RB, RT, 16'h0044));
        put(enc_r(FN_XOR, V0, RT, V0));
        finish_program(2);
    endtask

    task automatic build_branch_test();
        bit [31:0] target;
        start_program();
        put(enc_i(OP_ADDIU, R0, RX, 16'd5));
        put(enc_i(OP_ADDIU, R0, RY, 16'd5));
        put(enc_i(OP_ADDIU, R0, RT, 16'd7));
        put(enc_i(OP_BEQ, RX, RY, 16'd1));
        add_v0(16'h0001);
        add_v0(16'h0002);
        put(enc_i(OP_BEQ, RX, RT, 16'd1));
        add_v0(16'h0004);
        add_v0(16'h0008);
        put(enc_i(OP_BNE, RX, RT, 16'd1));
        add_v0(16'h0010);
        add_v0(16'h0020);
        put(enc_i(OP_BNE, RX, RY, 16'd1));
        add_v0(16'h0040);
        add_v0(16'h0080);
        put(enc_j(pc_at + 32'd8));
        add_v0(16'h0100);
        add_v0(16'h0200);
        // LUI, ORI and JR come before the skipped add
        target = pc_at + 32'd16;
        load_const(RC, target);
        put(enc_r(FN_JR, RC, R0, R0));
        add_v0(16'h0400);
        add_v0(16'h0800);
        // Backward loop of three passes
        put(enc_i(OP_ADDIU, R0, RX, 16'd3));
        add_v0(16'h1000);
        put(enc_i(OP_ADDIU, RX, RX, 16'hFFFF));
        put(enc_i(OP_BNE, RX, R0, 16'hFFFD));
        finish_program(3);
    endtask

    task automatic build_halt_test();
        start_program();
        put(enc_i(OP_ADDIU, R0, V0, 16'h0055));
        put(enc_r(FN_JR, R0, R0, R0));
        add_v0(16'h0100);
        finish_program(4);
    endtask

    // Avalon slave with random wait states
    always @(posedge clk) begin
        #DRIVE_DELAY;
        rng         = xorshift32(rng);
        waitrequest = wait_enable && rng[0] && (wait_run < MAX_WAIT);
        wait_run    = waitrequest ? wait_run + 1 : 0;
        readdata    = read ? dut_word(address) : 32'h0;
    end

    // Stores complete on the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(read && write)) else begin
                $display("Read and write both high at address %h", address);
                note_error();
            end
            if (write && !waitrequest) begin
                assert (byteenable === 4'hF) else begin
                    $display("** Error: byteenable = %h, expected f", byteenable);
                    note_error();
                end
                assert (exp_mem.exists(address) && exp_word(address) === writedata) else begin
                    $display("** Error: writedata = %h at address %h, expected %h",
                             writedata, address, exp_word(address));
                    note_error();
                end
                dut_mem[address] = writedata;
            end
        end
    end

    always begin
        @(compare_req);
        assert (register_v0 === exp_v0) else begin
            $display("** Error: register_v0 = %h, expected %h", register_v0, exp_v0);
            note_error();
        end
        assert (dut_mem.num() == exp_mem.num()) else begin
            $display("Memory holds %0d words, the model holds %0d", dut_mem.num(), exp_mem.num());
            note_error();
        end
        foreach (exp_mem[a]) begin
            assert (dut_word(a) === exp_mem[a]) else begin
                $display("** Error: memory[%h] = %h, expected %h", a, dut_word(a), exp_mem[a]);
                note_error();
            end
        end
        // Halted core keeps the bus idle
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            assert (!active && !read && !write) else begin
                $display("Bus not idle after halt, active %b read %b write %b",
                         active, read, write);
                note_error();
            end
        end
        -> compare_ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the core did not halt", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic run_test(int t, bit waits);
        wait_enable = waits;
        dut_mem     = imgs[t];
        exp_mem     = imgs[t];
        exp_v0      = ref_run(exp_mem, 1000);
        run_errors  = 0;
        reset       = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        while (active) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        -> compare_req;
        @(compare_ack);
        if (run_errors != 0) begin
            failed_runs++;
        end
        $display("test %0d %s%s: %s", t + 1, test_names[t], waits ? " with wait states" : "",
                 (run_errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        rng         = 32'd16;
        wait_enable = 1'b0;
        wait_run    = 0;
        cycles      = 0;
        errors      = 0;
        run_errors  = 0;
        failed_runs = 0;
        test_names  = '{"r-type alu", "immediates", "sw and lw", "branches", "jr halt"};
        build_alu_test();
        build_imm_test();
        build_mem_test();
        build_branch_test();
        build_halt_test();
        cycle_limit = 200;
        for (int r = 0; r < NUM_RUNS; r++) begin
            cycle_limit += imgs[r % NUM_TESTS].num() * 2 * (1 + MAX_WAIT)
                           + RESET_CYCLES + HOLD_CYCLES + 4;
        end
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_test((r < NUM_TESTS) ? r : r - NUM_TESTS, r >= NUM_TESTS);
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_RUNS, failed_runs, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hw/alu_execute.sv
module alu_execute import mips_pkg::*; (
    input  decode_t dec,
    input  word_t   rs_data,
    input  word_t   rt_data,
    output word_t   result,
    output logic    branch_taken,
    output word_t   mem_addr
);

    word_t      op_b;
    logic [4:0] sh;

    assign op_b = dec.use_imm ? dec.imm : rt_data;

    // Shift distance from shamt or from the low bits of rs
    assign sh = dec.shift_by_reg ? rs_data[4:0] : dec.shamt;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    result = rs_data + op_b;
            ALU_SUB:    result = rs_data - op_b;
            ALU_AND:    result = rs_data & op_b;
            ALU_OR:     result = rs_data | op_b;
            ALU_XOR:    result = rs_data ^ op_b;
            ALU_SLT:    result = {31'b0, $signed(rs_data) < $signed(op_b)};
            ALU_SLTU:   result = {31'b0, rs_data < op_b};
            // Shifts always take rt as the value
            ALU_SLL:    result = rt_data << sh;
            ALU_SRL:    result = rt_data >> sh;
            ALU_SRA:    result = $signed(rt_data) >>> sh;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (dec.branch)
            BR_BEQ:  branch_taken = (rs_data == rt_data);
            BR_BNE:  branch_taken = (rs_data != rt_data);
            default: branch_taken = 1'b0;
        endcase
    end

    // Word address for LW and SW
    assign mem_addr = rs_data + dec.imm;

endmodule

// File: hw/bus_sequencer.sv
module bus_sequencer import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  decode_t dec,
    input  word_t   mem_addr,
    input  word_t   store_data,
    input  word_t   next_pc,
    input  logic    waitrequest,
    input  word_t   readdata,
    output word_t   instr,
    output word_t   pc,
    output word_t   load_data,
    output logic    exec_done,
    output logic    mem_done,
    output word_t   address,
    output logic    read,
    output logic    write,
    output word_t   writedata,
    output logic    active
);

    cpu_state_t state;
    logic       is_mem;
    logic       fetch_done;
    logic       halt_next;

    assign is_mem     = dec.is_load || dec.is_store;
    assign fetch_done = (state == FETCH) && read && !waitrequest;
    assign exec_done  = (state == EXEC) && !is_mem && !dec.illegal;
    assign mem_done   = (state == MEM) && !waitrequest;
    assign halt_next  = (next_pc == HALT_ADDRESS);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_VECTOR;
            read  <= 1'b0;
            write <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    // Only the first fetch after reset enters with read low
                    if (!read) begin
                        read <= 1'b1;
                    end else if (!waitrequest) begin
                        read  <= 1'b0;
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (dec.illegal) begin
                        state <= HALT;
                    end else if (is_mem) begin
                        state <= MEM;
                        read  <= dec.is_load;
                        write <= dec.is_store;
                    end else begin
                        pc    <= next_pc;
                        state <= halt_next ? HALT : FETCH;
                        read  <= !halt_next;
                    end
                end
                MEM: begin
                    if (!waitrequest) begin
                        pc    <= next_pc;
                        state <= halt_next ? HALT : FETCH;
                        read  <= !halt_next;
                        write <= 1'b0;
                    end
                end
                default: begin
                    read  <= 1'b0;
                    write <= 1'b0;
                end
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= readdata;
        end
    end

    // Address and data stay steady while waitrequest is high
    assign address   = (state == MEM) ? mem_addr : pc;
    assign writedata = store_data;
    // readdata is valid in the completing MEM cycle
    assign load_data = readdata;
    assign active    = (state != HALT);

endmodule

// File: hw/instr_decode.sv
module instr_decode import mips_pkg::*; (
    input  word_t   instr,
    output decode_t dec
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_ADD;
        dec.branch = BR_NONE;
        dec.shamt  = instr[10:6];
        dec.target = instr[25:0];
        dec.dest   = rt;
        dec.imm    = {{16{instr[15]}}, instr[15:0]};

        case (opcode)
            OP_R: begin
                dec.dest      = rd;
                dec.reg_write = 1'b1;
                // Variable shifts have funct bit 2 set
                dec.shift_by_reg = (instr[5:3] == 3'b000) && instr[2];
                case (funct)
                    FN_ADDU:         dec.alu_op = ALU_ADD;
                    FN_SUBU:         dec.alu_op = ALU_SUB;
                    FN_AND:          dec.alu_op = ALU_AND;
                    FN_OR:           dec.alu_op = ALU_OR;
                    FN_XOR:          dec.alu_op = ALU_XOR;
                    FN_SLT:          dec.alu_op = ALU_SLT;
                    FN_SLTU:         dec.alu_op = ALU_SLTU;
                    FN_SLL, FN_SLLV: dec.alu_op = ALU_SLL;
                    FN_SRL, FN_SRLV: dec.alu_op = ALU_SRL;
                    FN_SRA, FN_SRAV: dec.alu_op = ALU_SRA;
                    FN_JR: begin
                        dec.reg_write = 1'b0;
                        dec.branch    = BR_JR;
                    end
                    default: begin
                        dec.reg_write = 1'b0;
                        dec.illegal   = 1'b1;
                    end
                endcase
            end
            OP_J:   dec.branch = BR_JUMP;
            OP_BEQ: dec.branch = BR_BEQ;
            OP_BNE: dec.branch = BR_BNE;
            OP_SW: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.is_load   = (opcode == OP_LW);
            end
            default: dec.illegal = 1'b1;
        endcase

        // Operation and extension of the immediate forms
        case (opcode)
            OP_SLTI:  dec.alu_op = ALU_SLT;
            OP_SLTIU: dec.alu_op = ALU_SLTU;
            OP_ANDI:  dec.alu_op = ALU_AND;
            OP_ORI:   dec.alu_op = ALU_OR;
            OP_XORI:  dec.alu_op = ALU_XOR;
            OP_LUI:   dec.alu_op = ALU_PASS_B;
            default:  ;
        endcase
        if (opcode inside {OP_ANDI, OP_ORI, OP_XORI}) begin
            dec.imm = {16'h0000, instr[15:0]};
        end
        if (opcode == OP_LUI) begin
            dec.imm = {instr[15:0], 16'h0000};
        end

        // Writes to $zero are dropped here
        if (dec.dest == '0) begin
            dec.reg_write = 1'b0;
        end
    end

endmodule

// File: hw/mips_cpu_bus.sv
module mips_cpu_bus import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,

    // Avalon master
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    decode_t   dec;
    word_t     instr;
    word_t     pc;
    word_t     load_data;
    word_t     rs_data;
    word_t     rt_data;
    word_t     alu_result;
    word_t     mem_addr;
    word_t     next_pc;
    word_t     wr_data;
    reg_addr_t wr_addr;
    logic      wr_en;
    logic      branch_taken;
    logic      exec_done;
    logic      mem_done;

    instr_decode i_instr_decode (
        .instr (instr),
        .dec   (dec)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (instr[25:21]),
        .rt_addr (instr[20:16]),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    alu_execute i_alu_execute (
        .dec          (dec),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .result       (alu_result),
        .branch_taken (branch_taken),
        .mem_addr     (mem_addr)
    );

    result_select i_result_select (
        .dec          (dec),
        .pc           (pc),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .rs_data      (rs_data),
        .load_data    (load_data),
        .exec_done    (exec_done),
        .mem_done     (mem_done),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .next_pc      (next_pc)
    );

    bus_sequencer i_bus_sequencer (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .mem_addr    (mem_addr),
        .store_data  (rt_data),
        .next_pc     (next_pc),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .instr       (instr),
        .pc          (pc),
        .load_data   (load_data),
        .exec_done   (exec_done),
        .mem_done    (mem_done),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .active      (active)
    );

    // Word accesses only
    assign byteenable = 4'b1111;

endmodule

// File: hw/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_VECTOR = 32'hBFC0_0000;
    localparam word_t HALT_ADDRESS = 32'h0000_0000;
    localparam int    NUM_REGS     = 32;
    localparam int    REG_V0       = 2;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_R     = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_JUMP, BR_JR
    } branch_t;

    typedef enum logic [1:0] {
        FETCH, EXEC, MEM, HALT
    } cpu_state_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        use_imm;
        // Already sign or zero extended
        word_t       imm;
        logic [4:0]  shamt;
        logic        shift_by_reg;
        reg_addr_t   dest;
        logic        reg_write;
        logic        is_load;
        logic        is_store;
        branch_t     branch;
        logic [25:0] target;
        logic        illegal;
    } decode_t;

endpackage

// File: hw/reg_file.sv
module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     v0
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $zero is hard-wired
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    // Observation tap
    assign v0 = regs[REG_V0];

endmodule

// File: hw/result_select.sv
module result_select import mips_pkg::*; (
    input  decode_t   dec,
    input  word_t     pc,
    input  word_t     alu_result,
    input  logic      branch_taken,
    input  word_t     rs_data,
    input  word_t     load_data,
    input  logic      exec_done,
    input  logic      mem_done,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output word_t     next_pc
);

    word_t pc_plus4;
    word_t branch_target;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {dec.imm[29:0], 2'b00};

    // Load results are written when MEM completes
    assign wr_en   = dec.reg_write && (dec.is_load ? mem_done : exec_done);
    assign wr_addr = dec.dest;
    assign wr_data = dec.is_load ? load_data : alu_result;

    // No delay slot
    always_comb begin
        case (dec.branch)
            BR_BEQ, BR_BNE: next_pc = branch_taken ? branch_target : pc_plus4;
            BR_JUMP:        next_pc = {pc[31:28], dec.target, 2'b00};
            BR_JR:          next_pc = rs_data;
            default:        next_pc = pc_plus4;
        endcase
    end

endmodule

// File: mips_cpu.f
+incdir+include
hw/mips_pkg.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/alu_execute.sv
hw/result_select.sv
hw/bus_sequencer.sv
hw/mips_cpu_bus.sv
bench/tb_mips_cpu_bus.sv
